// File: common/rv_core_pkg.sv
// rv32i core package
// shared widths, the instruction word views, opcodes and immediate decode

`default_nettype none

package rv_core_pkg;

    localparam int XLEN   = 32;  // data and address width
    localparam int REG_AW = 5;   // register address width

    ////////////////////
    // instruction word, one 32-bit word seen in each base format
    typedef union packed {
        struct packed {
            logic [6:0]        funct7;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } r;
        struct packed {
            logic [11:0]       imm_11_0;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } i;
        struct packed {
            logic [6:0]        imm_11_5;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [4:0]        imm_4_0;
            logic [6:0]        opcode;
        } s;
        struct packed {
            logic              imm_12;
            logic [5:0]        imm_10_5;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [3:0]        imm_4_1;
            logic              imm_11;
            logic [6:0]        opcode;
        } b;
        struct packed {
            logic [19:0]       imm_31_12;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } u;
        struct packed {
            logic              imm_20;
            logic [9:0]        imm_10_1;
            logic              imm_11;
            logic [7:0]        imm_19_12;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } j;
    } rv_instr_u;

    ////////////////////
    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;  // addi x0, x0, 0

    ////////////////////
    // sign-extended immediates, bit 31 is the sign in every format
    function automatic logic [XLEN-1:0] imm_i(rv_instr_u instr);
        return {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    endfunction

    function automatic logic [XLEN-1:0] imm_s(rv_instr_u instr);
        return {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    endfunction

    function automatic logic [XLEN-1:0] imm_b(rv_instr_u instr);
        return {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                instr.b.imm_4_1, 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] imm_u(rv_instr_u instr);
        return {instr.u.imm_31_12, 12'b0};
    endfunction

    function automatic logic [XLEN-1:0] imm_j(rv_instr_u instr);
        return {{12{instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
                instr.j.imm_10_1, 1'b0};
    endfunction

endpackage

`default_nettype wire

// File: rtl/reg_file.sv
// register file
// x1..x31 with two registered read ports, one write port and write-through

`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic [REG_AW-1:0] raddr_a_i,  // rs1 of the fetch instruction
    input  logic [REG_AW-1:0] raddr_b_i,  // rs2 of the fetch instruction
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i,
    input  logic              wr_en_i,
    output logic [XLEN-1:0]   rdata_a_o,  // valid in execute
    output logic [XLEN-1:0]   rdata_b_o
);

    logic [XLEN-1:0] regs [1:2**REG_AW-1];  // no storage behind x0
    logic            wr_hit;                // write that lands in a real register

    assign wr_hit = wr_en_i && (waddr_i != '0);

    always_ff @(posedge clk_i) begin
        if (wr_hit) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // read ports, a same-cycle write passes straight through
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            rdata_a_o <= '0;
            rdata_b_o <= '0;
        end else begin
            if (raddr_a_i == '0)                          rdata_a_o <= '0;
            else if (wr_hit && (waddr_i == raddr_a_i))    rdata_a_o <= wdata_i;
            else                                          rdata_a_o <= regs[raddr_a_i];

            if (raddr_b_i == '0)                          rdata_b_o <= '0;
            else if (wr_hit && (waddr_i == raddr_b_i))    rdata_b_o <= wdata_i;
            else                                          rdata_b_o <= regs[raddr_b_i];
        end
    end

    // x0 reads back as zero one cycle later on either port
    a_x0_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        (raddr_a_i == '0) |=> (rdata_a_o == '0));
    b_x0_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        (raddr_b_i == '0) |=> (rdata_b_o == '0));

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
// fetch unit
// PC register and next fetch address, no-op injection on redirect or stall,
// and the fetch to execute pipeline registers

`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_ADDR = '0  // first address presented
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic [XLEN-1:0] inst_rdata_i,  // word for f_pc_o
    input  logic            ext_stall_i,
    input  logic            redirect_i,    // taken branch or jump in execute
    input  logic [XLEN-1:0] target_i,
    output logic [XLEN-1:0] inst_raddr_o,
    output rv_instr_u       f_instr_o,
    output rv_instr_u       x_instr_o,
    output logic [XLEN-1:0] f_pc_o,        // address of the word now arriving
    output logic [XLEN-1:0] x_pc_o
);

    logic [XLEN-1:0] f_next_pc;
    logic            f_word_vld;  // low in the first cycle out of reset

    // redirect first so a branch under stall still lands on its target
    always_comb begin
        if (redirect_i) begin
            f_next_pc = target_i;
        end else if (ext_stall_i) begin
            f_next_pc = f_pc_o;                   // present the same address again
        end else begin
            f_next_pc = f_pc_o + XLEN'(4);
        end
    end

    assign inst_raddr_o = f_next_pc;

    // the arriving word is dropped behind a redirect, under stall, and before
    // the first real fetch has returned
    assign f_instr_o = (redirect_i || ext_stall_i || !f_word_vld) ? NOP_WORD : inst_rdata_i;

    ////////////////////
    // pipeline registers
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            f_pc_o     <= RESET_ADDR - XLEN'(4);
            f_word_vld <= 1'b0;
            x_instr_o  <= '0;
            x_pc_o     <= '0;
        end else begin
            f_pc_o     <= f_next_pc;
            f_word_vld <= 1'b1;
            x_instr_o  <= f_instr_o;
            x_pc_o     <= f_pc_o;
        end
    end

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        f_pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: execute/operand_mux.sv
// operand stage
// forwards the write-back value into execute and picks the two ALU operands

`timescale 1ns/1ps
`default_nettype none

module operand_mux import rv_core_pkg::*; (
    input  rv_instr_u         x_instr_i,
    input  logic [XLEN-1:0]   x_pc_i,
    input  logic [XLEN-1:0]   rs1_data_i,  // register file, read during fetch
    input  logic [XLEN-1:0]   rs2_data_i,
    input  logic [REG_AW-1:0] w_rd_i,
    input  logic              w_wr_en_i,   // already low for x0
    input  logic [XLEN-1:0]   w_wdata_i,
    output logic [XLEN-1:0]   op_a_o,
    output logic [XLEN-1:0]   op_b_o,
    output logic [XLEN-1:0]   rs1_fwd_o,   // also feeds branch unit
    output logic [XLEN-1:0]   rs2_fwd_o    // also store data
);

    logic [6:0] opcode;

    assign opcode = x_instr_i.r.opcode;

    ////////////////////
    // forwarding from write-back
    assign rs1_fwd_o = (w_wr_en_i && (w_rd_i == x_instr_i.r.rs1)) ? w_wdata_i : rs1_data_i;
    assign rs2_fwd_o = (w_wr_en_i && (w_rd_i == x_instr_i.r.rs2)) ? w_wdata_i : rs2_data_i;

    ////////////////////
    // operand A: PC, zero or rs1
    always_comb begin
        case (opcode)
            OPC_AUIPC, OPC_JAL, OPC_JALR: op_a_o = x_pc_i;  // link and auipc add to pc
            OPC_LUI:                      op_a_o = '0;
            default:                      op_a_o = rs1_fwd_o;
        endcase
    end

    // operand B: rs2 or the immediate of the format
    always_comb begin
        case (opcode)
            OPC_OP, OPC_BRANCH:   op_b_o = rs2_fwd_o;
            OPC_OP_IMM, OPC_LOAD: op_b_o = imm_i(x_instr_i);
            OPC_STORE:            op_b_o = imm_s(x_instr_i);  // address = rs1 + offset
            OPC_LUI, OPC_AUIPC:   op_b_o = imm_u(x_instr_i);
            OPC_JAL, OPC_JALR:    op_b_o = XLEN'(4);          // link value pc + 4
            default:              op_b_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: execute/alu.sv
// RV32I ALU
// add, sub, shifts, compares and logic ops on the two execute operands

`timescale 1ns/1ps
`default_nettype none

module alu import rv_core_pkg::*; (
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  rv_instr_u       x_instr_i,
    output logic [XLEN-1:0] result_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        alt;        // funct7 bit 5, sub or sra
    logic        is_op;      // register-register
    logic        is_arith;   // register-register or register-immediate
    logic [4:0]  shamt;
    logic [XLEN-1:0] sum;

    assign opcode   = x_instr_i.r.opcode;
    assign funct3   = x_instr_i.r.funct3;
    assign alt      = x_instr_i.r.funct7[5];  // imm bit 10 for srai
    assign is_op    = (opcode == OPC_OP);
    assign is_arith = is_op || (opcode == OPC_OP_IMM);
    assign shamt    = op_b_i[4:0];
    assign sum      = op_a_i + op_b_i;

    always_comb begin
        result_o = sum;  // addresses, lui, auipc and link values
        if (is_arith) begin
            case (funct3)
                3'b000: result_o = (is_op && alt) ? op_a_i - op_b_i : sum;  // no subi
                3'b001: result_o = op_a_i << shamt;
                3'b010: result_o = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
                3'b011: result_o = {{(XLEN-1){1'b0}}, op_a_i < op_b_i};
                3'b100: result_o = op_a_i ^ op_b_i;
                3'b101: begin
                    if (alt) begin
                        result_o = $unsigned($signed(op_a_i) >>> shamt);
                    end else begin
                        result_o = op_a_i >> shamt;
                    end
                end
                3'b110: result_o = op_a_i | op_b_i;
                default: result_o = op_a_i & op_b_i;  // 3'b111
            endcase
        end
    end

endmodule

`default_nettype wire

// File: execute/branch_unit.sv
// branch unit
// branch condition, jump and branch targets, and the redirect to fetch

`timescale 1ns/1ps
`default_nettype none

module branch_unit import rv_core_pkg::*; (
    input  rv_instr_u       x_instr_i,
    input  logic [XLEN-1:0] x_pc_i,
    input  logic [XLEN-1:0] rs1_fwd_i,
    input  logic [XLEN-1:0] rs2_fwd_i,
    output logic            redirect_o,
    output logic [XLEN-1:0] target_o
);

    logic [6:0] opcode;
    logic       br_eq;
    logic       br_lt;    // signed
    logic       br_ltu;
    logic       br_taken;
    logic [XLEN-1:0] jalr_sum;

    assign opcode = x_instr_i.b.opcode;
    assign br_eq  = (rs1_fwd_i == rs2_fwd_i);
    assign br_lt  = ($signed(rs1_fwd_i) < $signed(rs2_fwd_i));
    assign br_ltu = (rs1_fwd_i < rs2_fwd_i);

    // condition by funct3, 010 and 011 are not branches
    always_comb begin
        case (x_instr_i.b.funct3)
            3'b000:  br_taken = br_eq;    // beq
            3'b001:  br_taken = !br_eq;   // bne
            3'b100:  br_taken = br_lt;    // blt
            3'b101:  br_taken = !br_lt;   // bge
            3'b110:  br_taken = br_ltu;   // bltu
            3'b111:  br_taken = !br_ltu;  // bgeu
            default: br_taken = 1'b0;
        endcase
    end

    assign redirect_o = (opcode == OPC_JAL) || (opcode == OPC_JALR)
                     || ((opcode == OPC_BRANCH) && br_taken);

    assign jalr_sum = rs1_fwd_i + imm_i(x_instr_i);

    always_comb begin
        case (opcode)
            OPC_JAL:  target_o = x_pc_i + imm_j(x_instr_i);
            OPC_JALR: target_o = {jalr_sum[XLEN-1:1], 1'b0};  // lsb cleared
            default:  target_o = x_pc_i + imm_b(x_instr_i);   // only used when taken
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/writeback_unit.sv
// write-back unit
// store strobe from execute, then the write-back register stage and
// the register write enable and data

`timescale 1ns/1ps
`default_nettype none

module writeback_unit import rv_core_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  rv_instr_u         x_instr_i,
    input  logic [XLEN-1:0]   alu_result_i,
    input  logic [XLEN-1:0]   data_rdata_i,  // load data, one cycle after the address
    output logic              data_wr_en_o,
    output logic [2:0]        funct3_o,
    output logic [REG_AW-1:0] w_rd_o,
    output logic              w_wr_en_o,
    output logic [XLEN-1:0]   w_wdata_o
);

    logic [6:0]      w_opcode;
    logic [XLEN-1:0] w_alu_result;

    // memory side, live during the execute cycle
    assign data_wr_en_o = (x_instr_i.s.opcode == OPC_STORE);
    assign funct3_o     = x_instr_i.s.funct3;  // access size to the data memory

    ////////////////////
    // write-back stage
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            w_rd_o   <= '0;
            w_opcode <= '0;
        end else begin
            w_rd_o   <= x_instr_i.r.rd;
            w_opcode <= x_instr_i.r.opcode;
        end
    end

    always_ff @(posedge clk_i) begin
        w_alu_result <= alu_result_i;
    end

    // store and branch have no rd, the rd field holds immediate bits there
    assign w_wr_en_o = (w_opcode != OPC_STORE) && (w_opcode != OPC_BRANCH) && (w_rd_o != '0);
    assign w_wdata_o = (w_opcode == OPC_LOAD) ? data_rdata_i : w_alu_result;

    // an execute instruction aimed at x0 never writes one cycle later
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
        (x_instr_i.r.rd == '0) |=> !w_wr_en_o);

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
// rv32i core top
// three stages for fetch, execute and write-back on synchronous memories

`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic [XLEN-1:0] inst_rdata_i,
    input  logic [XLEN-1:0] data_rdata_i,
    input  logic            ext_stall_i,   // hold pc and feed a no-op
    output logic [XLEN-1:0] inst_raddr_o,
    output logic [XLEN-1:0] data_addr_o,
    output logic [XLEN-1:0] data_wdata_o,
    output logic            data_wr_en_o,
    output logic [2:0]      funct3_o
);

    rv_instr_u         f_instr;
    rv_instr_u         x_instr;
    logic [XLEN-1:0]   x_pc;
    logic              redirect;
    logic [XLEN-1:0]   br_target;
    logic [XLEN-1:0]   rs1_data;   // register file outputs
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   rs1_fwd;
    logic [XLEN-1:0]   rs2_fwd;
    logic [XLEN-1:0]   alu_result;
    logic [REG_AW-1:0] w_rd;
    logic              w_wr_en;
    logic [XLEN-1:0]   w_wdata;

    ////////////////////
    // fetch
    fetch_unit #(.RESET_ADDR(RESET_ADDR)) u_fetch (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_rdata_i (inst_rdata_i),
        .ext_stall_i  (ext_stall_i),
        .redirect_i   (redirect),
        .target_i     (br_target),
        .inst_raddr_o (inst_raddr_o),
        .f_instr_o    (f_instr),
        .x_instr_o    (x_instr),
        .f_pc_o       (),
        .x_pc_o       (x_pc)
    );

    reg_file u_regs (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .raddr_a_i (f_instr.r.rs1),
        .raddr_b_i (f_instr.r.rs2),
        .waddr_i   (w_rd),
        .wdata_i   (w_wdata),
        .wr_en_i   (w_wr_en),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data)
    );

    ////////////////////
    // execute
    operand_mux u_opmux (
        .x_instr_i  (x_instr),
        .x_pc_i     (x_pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .w_rd_i     (w_rd),
        .w_wr_en_i  (w_wr_en),
        .w_wdata_i  (w_wdata),
        .op_a_o     (op_a),
        .op_b_o     (op_b),
        .rs1_fwd_o  (rs1_fwd),
        .rs2_fwd_o  (rs2_fwd)
    );

    alu u_alu (
        .op_a_i    (op_a),
        .op_b_i    (op_b),
        .x_instr_i (x_instr),
        .result_o  (alu_result)
    );

    branch_unit u_branch (
        .x_instr_i  (x_instr),
        .x_pc_i     (x_pc),
        .rs1_fwd_i  (rs1_fwd),
        .rs2_fwd_i  (rs2_fwd),
        .redirect_o (redirect),
        .target_o   (br_target)
    );

    assign data_addr_o  = alu_result;  // load and store address
    assign data_wdata_o = rs2_fwd;

    ////////////////////
    // write-back
    writeback_unit u_wb (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .x_instr_i    (x_instr),
        .alu_result_i (alu_result),
        .data_rdata_i (data_rdata_i),
        .data_wr_en_o (data_wr_en_o),
        .funct3_o     (funct3_o),
        .w_rd_o       (w_rd),
        .w_wr_en_o    (w_wr_en),
        .w_wdata_o    (w_wdata)
    );

endmodule

`default_nettype wire

// File: dv/rv_core_checks.svh
// store checks for the core testbench
// typed compare tasks and the check and error counters

`ifndef RV_CORE_CHECKS_SVH
`define RV_CORE_CHECKS_SVH

int error_count = 0;  // failed checks of any kind
int check_count = 0;  // compares done

// one word of store address or data
task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
endtask

// access size passed out to the data memory
task automatic verify_funct3(input string name, input logic [2:0] got,
                             input logic [2:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

// a store that no record asked for, e.g. from a branch shadow
task automatic report_extra_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
    error_count++;
    $display("store to %h with data %h was not expected", addr, data);
endtask

`endif

// File: dv/tb_rv_core.sv
// testbench for the rv32i core
// memory models, pattern file loading, random stall and store checks

`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

    `include "rv_core_checks.svh"

    localparam int MEM_WORDS = 256;
    localparam int STORE_TIMEOUT = 2000;  // cycles per expected store

    logic            clk_i;
    logic            rst_i;
    logic [XLEN-1:0] inst_rdata_i;
    logic [XLEN-1:0] data_rdata_i;
    logic            ext_stall_i;
    logic [XLEN-1:0] inst_raddr_o;
    logic [XLEN-1:0] data_addr_o;
    logic [XLEN-1:0] data_wdata_o;
    logic            data_wr_en_o;
    logic [2:0]      funct3_o;

    logic [XLEN-1:0] imem [MEM_WORDS];
    logic [XLEN-1:0] dmem [MEM_WORDS];

    logic [XLEN-1:0] exp_addr [$];   // expect records in program order
    logic [XLEN-1:0] exp_data [$];
    logic [2:0]      exp_f3   [$];
    logic [XLEN-1:0] got_addr [$];   // stores seen on the bus
    logic [XLEN-1:0] got_data [$];
    logic [2:0]      got_f3   [$];

    int seed = 32'h4f26_bc49;
    int stall_cnt = 0;
    bit timed_out = 1'b0;

    rv_core #(.RESET_ADDR('0)) DUT (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_rdata_i (inst_rdata_i),
        .data_rdata_i (data_rdata_i),
        .ext_stall_i  (ext_stall_i),
        .inst_raddr_o (inst_raddr_o),
        .data_addr_o  (data_addr_o),
        .data_wdata_o (data_wdata_o),
        .data_wr_en_o (data_wr_en_o),
        .funct3_o     (funct3_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    ////////////////////
    // memories with a one-cycle registered read
    always @(posedge clk_i) begin
        inst_rdata_i <= imem[inst_raddr_o[9:2]];
        data_rdata_i <= dmem[data_addr_o[9:2]];
        if (data_wr_en_o) begin
            dmem[data_addr_o[9:2]] <= data_wdata_o;  // word wide write that ignores funct3
        end
    end

    // store monitor samples mid cycle once the execute outputs settle
    always @(negedge clk_i) begin
        if (!rst_i && data_wr_en_o) begin
            got_addr.push_back(data_addr_o);
            got_data.push_back(data_wdata_o);
            got_f3.push_back(funct3_o);
        end
    end

    // no stall during reset, a fixed stall window and then random stall
    always @(posedge clk_i) begin
        #1;
        if (stall_cnt < 14) begin
            ext_stall_i = (stall_cnt >= 10);
        end else begin
            ext_stall_i = (($random(seed) & 3) == 0);  // about one cycle in four
        end
        stall_cnt++;
    end

    ////////////////////
    task automatic load_patterns();
        int fd;
        int n;
        string line;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        logic [XLEN-1:0] f;
        fd = $fopen("dv/rv_core_patterns.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("pattern file dv/rv_core_patterns.txt could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                break;
            end
            if ($sscanf(line, "P %h %h", a, d) == 2) begin
                imem[a[9:2]] = d;
            end else if ($sscanf(line, "E %h %h %h", a, d, f) == 3) begin
                exp_addr.push_back(a);
                exp_data.push_back(d);
                exp_f3.push_back(f[2:0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_for_store(output bit found);
        int cycles;
        cycles = 0;
        while (got_addr.size() == 0 && cycles < STORE_TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        found = (got_addr.size() != 0);
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    ////////////////////
    // main flow
    initial begin
        bit found;
        int errs_before;
        rst_i       = 1'b1;
        ext_stall_i = 1'b0;
        inst_rdata_i = '0;
        data_rdata_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = NOP_WORD | (XLEN'(i) << 20);  // addi x0, x0, index
            dmem[i] = XLEN'(i) * 32'h9e37_79b9;
        end
        load_patterns();
        repeat (10) @(posedge clk_i);
        #1 rst_i = 1'b0;

        for (int k = 0; k < exp_addr.size(); k++) begin
            wait_for_store(found);
            if (!found) begin
                $display("expected store %0d to %h never appeared", k, exp_addr[k]);
                timed_out = 1'b1;
                break;
            end
            errs_before = error_count;
            compare_word("data_addr_o", got_addr.pop_front(), exp_addr[k]);
            compare_word("data_wdata_o", got_data.pop_front(), exp_data[k]);
            verify_funct3("funct3_o", got_f3.pop_front(), exp_f3[k]);
            $display("store %0d at %h: %s", k, exp_addr[k],
                     (error_count == errs_before) ? "ok" : "wrong");
        end

        if (!timed_out) begin
            repeat (40) @(posedge clk_i);  // core spins on its last jal
            while (got_addr.size() != 0) begin
                report_extra_store(got_addr.pop_front(), got_data.pop_front());
                void'(got_f3.pop_front());
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: compile.f
common/rv_core_pkg.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
execute/operand_mux.sv
execute/alu.sv
execute/branch_unit.sv
rtl/writeback_unit.sv
rtl/rv_core.sv
+incdir+dv
dv/tb_rv_core.sv

// File: Makefile
# Verilator flow for the rv32i core

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module rv_core

sim:
	verilator --binary --timing --assert -f compile.f --top-module tb_rv_core \
		-Mdir $(OBJ_DIR) -o Vtb_rv_core
	./$(OBJ_DIR)/Vtb_rv_core > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/rv_core_patterns.txt
# P <byte address> <instruction word>
# E <store address> <store data> <funct3>, in program order
P 00000000 00500093
P 00000004 FFD00113
P 00000008 002081B3
P 0000000C 10302023
P 00000010 40208233
P 00000014 10402223
P 00000018 001122B3
P 0000001C 00113333
P 00000020 10502423
P 00000024 10602623
P 00000028 40115393
P 0000002C 01C15413
P 00000030 10702823
P 00000034 10802A23
P 00000038 0F00C493
P 0000003C 00449513
P 00000040 10A02C23
P 00000044 123455B7
P 00000048 00001617
P 0000004C 10B02E23
P 00000050 12C02023
# store, load of the same word, byte store of the loaded value
P 00000054 12B02223
P 00000058 12400683
P 0000005C 12D00423
# branches, taken forms skip a store to 1F0
P 00000060 05500713
P 00000064 00108463
P 00000068 1E002823
P 0000006C 14E02023
P 00000070 00208463
P 00000074 14E02223
P 00000078 00209463
P 0000007C 1E002823
P 00000080 14E02423
P 00000084 00109463
P 00000088 14E02623
P 0000008C 00114463
P 00000090 1E002823
P 00000094 14E02823
P 00000098 0020C463
P 0000009C 14E02A23
P 000000A0 0020D463
P 000000A4 1E002823
P 000000A8 14E02C23
P 000000AC 00115463
P 000000B0 14E02E23
P 000000B4 0020E463
P 000000B8 1E002823
P 000000BC 16E02023
P 000000C0 00116463
P 000000C4 16E02223
P 000000C8 00117463
P 000000CC 1E002823
P 000000D0 16E02423
P 000000D4 0020F463
P 000000D8 16E02623
# jal and jalr with link stores, then a jal to itself
P 000000DC 008007EF
P 000000E0 1E002823
P 000000E4 16F02823
P 000000E8 01078867
P 000000EC 1E002823
P 000000F0 17002A23
P 000000F4 0000006F
E 00000100 00000002 2
E 00000104 00000008 2
E 00000108 00000001 2
E 0000010C 00000000 2
E 00000110 FFFFFFFE 2
E 00000114 0000000F 2
E 00000118 00000F50 2
E 0000011C 12345000 2
E 00000120 00001048 2
E 00000124 12345000 2
E 00000128 12345000 0
E 00000140 00000055 2
E 00000144 00000055 2
E 00000148 00000055 2
E 0000014C 00000055 2
E 00000150 00000055 2
E 00000154 00000055 2
E 00000158 00000055 2
E 0000015C 00000055 2
E 00000160 00000055 2
E 00000164 00000055 2
E 00000168 00000055 2
E 0000016C 00000055 2
E 00000170 000000E0 2
E 00000174 000000EC 2
